// File: source/iadc_sample_pkg.sv
`default_nettype none

package iadc_sample_pkg;

  localparam int SAMPLE_W         = 8;  // bits per adc sample.
  localparam int LANES_PER_CH     = 2;  // even and odd lanes.
  localparam int SAMPLES_PER_WORD = 8;  // samples per adc_clk cycle.

  // slot positions inside one channel of the dual view, msb first.
  localparam int IDX_EVEN_RISE = 3;
  localparam int IDX_ODD_RISE  = 2;
  localparam int IDX_EVEN_FALL = 1;
  localparam int IDX_ODD_FALL  = 0;

  // dual channel view, same bit order as the iddr packing.
  typedef struct packed {
    logic [2*LANES_PER_CH-1:0][SAMPLE_W-1:0] q;  // upper 32 bits.
    logic [2*LANES_PER_CH-1:0][SAMPLE_W-1:0] i;  // lower 32 bits.
  } iadc_dual_t;

  // interleaved view, t[0] is the oldest sample of the cycle.
  typedef struct packed {
    logic [SAMPLES_PER_WORD-1:0][SAMPLE_W-1:0] t;
  } iadc_inter_t;

  typedef union packed {
    iadc_dual_t  dual;
    iadc_inter_t inter;
  } iadc_word_u;

  localparam logic MODE_DUAL        = 1'b0;
  localparam logic MODE_INTERLEAVED = 1'b1;  // single channel, double rate.

endpackage

`default_nettype wire

// File: source/iadc_ctrl_pkg.sv
`default_nettype none

package iadc_ctrl_pkg;

  // adc reset pulse.
  localparam int DDRB_CYCLES = 16;                       // pulse length in adc_clk cycles.
  localparam int DDRB_CNT_W  = $clog2(DDRB_CYCLES + 1);  // fits the full load value.

  // out-of-range monitoring.
  localparam int OOR_CNT_W = 16;  // saturating counter width.
  localparam int OOR_CH    = 2;   // bit 0 is i, bit 1 is q.

endpackage

`default_nettype wire

// File: source/iadc_ddr_capture.sv
`timescale 1ns/1ps
`default_nettype none

module iadc_ddr_capture
  import iadc_sample_pkg::*;
  import iadc_ctrl_pkg::*;
(
  input  wire                adc_clk,
  input  wire                rst,
  input  wire [SAMPLE_W-1:0] data_i_even,
  input  wire [SAMPLE_W-1:0] data_i_odd,
  input  wire [SAMPLE_W-1:0] data_q_even,
  input  wire [SAMPLE_W-1:0] data_q_odd,
  input  wire                outofrange_i,
  input  wire                outofrange_q,
  input  wire                adc_sync,
  output iadc_word_u         cap_word,
  output logic [OOR_CH-1:0]  cap_oor_rise,
  output logic [OOR_CH-1:0]  cap_oor_fall,
  output logic               cap_sync
);

  // lane order is q_even, q_odd, i_even, i_odd from the top.
  logic [2*LANES_PER_CH-1:0][SAMPLE_W-1:0] lane_pins;
  logic [2*LANES_PER_CH-1:0][SAMPLE_W-1:0] lane_rise_q;
  logic [2*LANES_PER_CH-1:0][SAMPLE_W-1:0] lane_rise_r;
  logic [2*LANES_PER_CH-1:0][SAMPLE_W-1:0] lane_fall_q;
  logic [2*LANES_PER_CH-1:0][SAMPLE_W-1:0] lane_fall_r;
  logic [OOR_CH-1:0]                       oor_rise_q;
  logic [OOR_CH-1:0]                       oor_fall_q;
  logic                                    sync_q;

  assign lane_pins = {data_q_even, data_q_odd, data_i_even, data_i_odd};

  // falling edge half of each ddr pin.
  always_ff @(negedge adc_clk) begin
    if (rst) begin
      lane_fall_q <= '0;
      oor_fall_q  <= '0;
    end else begin
      lane_fall_q <= lane_pins;
      oor_fall_q  <= {outofrange_q, outofrange_i};
    end
  end

  // rising edge half, then both halves leave together on the next rising edge.
  always_ff @(posedge adc_clk) begin
    if (rst) begin
      lane_rise_q  <= '0;
      oor_rise_q   <= '0;
      sync_q       <= 1'b0;
      lane_rise_r  <= '0;
      lane_fall_r  <= '0;
      cap_oor_rise <= '0;
      cap_oor_fall <= '0;
      cap_sync     <= 1'b0;
    end else begin
      lane_rise_q  <= lane_pins;
      oor_rise_q   <= {outofrange_q, outofrange_i};
      sync_q       <= adc_sync;
      lane_rise_r  <= lane_rise_q;
      lane_fall_r  <= lane_fall_q;   // re-timed onto the rising edge.
      cap_oor_rise <= oor_rise_q;
      cap_oor_fall <= oor_fall_q;
      cap_sync     <= sync_q;        // same depth as the data.
    end
  end

  // pack as even rise, odd rise, even fall, odd fall per channel.
  always_comb begin
    cap_word.dual.q = {lane_rise_r[3], lane_rise_r[2], lane_fall_r[3], lane_fall_r[2]};
    cap_word.dual.i = {lane_rise_r[1], lane_rise_r[0], lane_fall_r[1], lane_fall_r[0]};
  end

endmodule

`default_nettype wire

// File: source/iadc_sample_order.sv
`timescale 1ns/1ps
`default_nettype none

module iadc_sample_order
  import iadc_sample_pkg::*;
(
  input  wire             adc_clk,
  input  wire             rst,
  input  wire             mode,
  input  wire iadc_word_u cap_word,
  input  wire             cap_sync,
  output iadc_word_u      samples,
  output logic            sync_out
);

  iadc_word_u reordered;

  // in interleaved mode i and q lanes alternate in time.
  always_comb begin
    reordered = cap_word;  // dual mode keeps the capture layout.
    if (mode == MODE_INTERLEAVED) begin
      // rise half first.
      reordered.inter.t[0] = cap_word.dual.i[IDX_EVEN_RISE];
      reordered.inter.t[1] = cap_word.dual.q[IDX_EVEN_RISE];
      reordered.inter.t[2] = cap_word.dual.i[IDX_ODD_RISE];
      reordered.inter.t[3] = cap_word.dual.q[IDX_ODD_RISE];
      // then the fall half.
      reordered.inter.t[4] = cap_word.dual.i[IDX_EVEN_FALL];
      reordered.inter.t[5] = cap_word.dual.q[IDX_EVEN_FALL];
      reordered.inter.t[6] = cap_word.dual.i[IDX_ODD_FALL];
      reordered.inter.t[7] = cap_word.dual.q[IDX_ODD_FALL];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      samples  <= '0;
      sync_out <= 1'b0;
    end else begin
      samples  <= reordered;
      sync_out <= cap_sync;  // stays with its word.
    end
  end

endmodule

`default_nettype wire

// File: source/iadc_oor_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module iadc_oor_monitor
  import iadc_ctrl_pkg::*;
(
  input  wire                   adc_clk,
  input  wire                   rst,
  input  wire [OOR_CH-1:0]      cap_oor_rise,
  input  wire [OOR_CH-1:0]      cap_oor_fall,
  input  wire                   oor_clear,
  output logic [2*OOR_CH-1:0]   adc_outofrange,
  output logic [OOR_CH-1:0]     oor_sticky,
  output logic [OOR_CNT_W-1:0]  oor_count_i,
  output logic [OOR_CNT_W-1:0]  oor_count_q
);

  logic                             clear_q;
  logic [OOR_CH-1:0]                hit;
  logic [OOR_CH-1:0][OOR_CNT_W-1:0] count;

  // a channel is out of range for the cycle if either half flagged.
  assign hit = cap_oor_rise | cap_oor_fall;

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      clear_q        <= 1'b0;
      adc_outofrange <= '0;
      oor_sticky     <= '0;
      count          <= '0;
    end else begin
      clear_q        <= oor_clear;
      adc_outofrange <= {cap_oor_fall, cap_oor_rise};  // q_fall, i_fall, q_rise, i_rise.
      if (clear_q) begin
        // clear takes priority over any flag this cycle
        oor_sticky <= '0;
        count      <= '0;
      end else begin
        oor_sticky <= oor_sticky | hit;
        for (int ch = 0; ch < OOR_CH; ch++) begin
          if (hit[ch] && (count[ch] != '1)) begin
            count[ch] <= count[ch] + 1'b1;  // saturates at all ones.
          end
        end
      end
    end
  end

  assign oor_count_i = count[0];
  assign oor_count_q = count[1];

endmodule

`default_nettype wire

// File: source/iadc_ddrb_gen.sv
`timescale 1ns/1ps
`default_nettype none

module iadc_ddrb_gen
  import iadc_ctrl_pkg::*;
(
  input  wire  adc_clk,
  input  wire  rst,
  input  wire  ddrb_req,
  output logic adc_ddrb
);

  logic                  req_q;
  logic [DDRB_CNT_W-1:0] remain;

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      req_q  <= 1'b0;
      remain <= '0;
    end else begin
      req_q <= ddrb_req & ~adc_ddrb;  // requests during the pulse are dropped.
      if (remain != '0) begin
        remain <= remain - 1'b1;
      end else if (req_q) begin
        remain <= DDRB_CNT_W'(DDRB_CYCLES);
      end
    end
  end

  // high while cycles are left.
  assign adc_ddrb = (remain != '0);

endmodule

`default_nettype wire

// File: source/iadc_infrastructure.sv
`timescale 1ns/1ps
`default_nettype none

module iadc_infrastructure
  import iadc_sample_pkg::*;
  import iadc_ctrl_pkg::*;
(
  input  wire                  adc_clk,
  input  wire                  rst,
  input  wire [SAMPLE_W-1:0]   data_i_even,
  input  wire [SAMPLE_W-1:0]   data_i_odd,
  input  wire [SAMPLE_W-1:0]   data_q_even,
  input  wire [SAMPLE_W-1:0]   data_q_odd,
  input  wire                  outofrange_i,
  input  wire                  outofrange_q,
  input  wire                  adc_sync,
  input  wire                  mode,
  input  wire                  ddrb_req,
  input  wire                  oor_clear,
  output iadc_word_u           samples,
  output logic                 sync_out,
  output logic [2*OOR_CH-1:0]  adc_outofrange,
  output logic [OOR_CH-1:0]    oor_sticky,
  output logic [OOR_CNT_W-1:0] oor_count_i,
  output logic [OOR_CNT_W-1:0] oor_count_q,
  output logic                 adc_ddrb
);

  iadc_word_u        cap_word;      // dual layout.
  logic              cap_sync;
  logic [OOR_CH-1:0] cap_oor_rise;
  logic [OOR_CH-1:0] cap_oor_fall;

  iadc_ddr_capture u_capture (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .data_i_even  (data_i_even),
    .data_i_odd   (data_i_odd),
    .data_q_even  (data_q_even),
    .data_q_odd   (data_q_odd),
    .outofrange_i (outofrange_i),
    .outofrange_q (outofrange_q),
    .adc_sync     (adc_sync),
    .cap_word     (cap_word),
    .cap_oor_rise (cap_oor_rise),
    .cap_oor_fall (cap_oor_fall),
    .cap_sync     (cap_sync)
  );

  iadc_sample_order u_order (
    .adc_clk  (adc_clk),
    .rst      (rst),
    .mode     (mode),
    .cap_word (cap_word),
    .cap_sync (cap_sync),
    .samples  (samples),
    .sync_out (sync_out)
  );

  iadc_oor_monitor u_oor (
    .adc_clk        (adc_clk),
    .rst            (rst),
    .cap_oor_rise   (cap_oor_rise),
    .cap_oor_fall   (cap_oor_fall),
    .oor_clear      (oor_clear),
    .adc_outofrange (adc_outofrange),
    .oor_sticky     (oor_sticky),
    .oor_count_i    (oor_count_i),
    .oor_count_q    (oor_count_q)
  );

  // reset pulse toward the adc.
  iadc_ddrb_gen u_ddrb (
    .adc_clk  (adc_clk),
    .rst      (rst),
    .ddrb_req (ddrb_req),
    .adc_ddrb (adc_ddrb)
  );

endmodule

`default_nettype wire

// File: sim/iadc_tb_model.svh
`ifndef IADC_TB_MODEL_SVH
`define IADC_TB_MODEL_SVH

// lane index 0 is i even, 1 is i odd, 2 is q even, 3 is q odd.

task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    $display("FAIL %s: expected 0x%0h, got 0x%0h at %0t ns", name, exp, got, $time);
    $display("TESTBENCH FAILED");
    $fatal(1, "value mismatch");
  end
endtask

// q channel in the upper half with each channel ordered even rise to odd fall.
function automatic logic [63:0] expect_dual(input logic [3:0][7:0] rise,
                                            input logic [3:0][7:0] fall);
  return {rise[2], rise[3], fall[2], fall[3], rise[0], rise[1], fall[0], fall[1]};
endfunction

// time order with the oldest sample in the low byte.
function automatic logic [63:0] expect_inter(input logic [3:0][7:0] rise,
                                             input logic [3:0][7:0] fall);
  return {fall[3], fall[1], fall[2], fall[0], rise[3], rise[1], rise[2], rise[0]};
endfunction

function automatic logic [OOR_CNT_W-1:0] next_count(input logic [OOR_CNT_W-1:0] cnt,
                                                    input logic hit,
                                                    input logic clr);
  logic [OOR_CNT_W-1:0] result;
  result = cnt;
  if (clr) begin
    result = '0;  // clear beats a flag.
  end else if (hit && (cnt != {OOR_CNT_W{1'b1}})) begin
    result = cnt + 1'b1;
  end
  return result;
endfunction

// taken only when the output was low before this edge and no pulse is pending.
function automatic bit ddrb_accepts(input int req_edge, input int rise_edge);
  return (req_edge - 1) >= (rise_edge + DDRB_CYCLES);
endfunction

function automatic logic ddrb_expected(input int now, input int rise_edge);
  return (now >= rise_edge) && (now < rise_edge + DDRB_CYCLES);
endfunction

`endif

// File: sim/tb_iadc_infrastructure.sv
`timescale 1ns/1ps
`default_nettype none

module tb_iadc_infrastructure
  import iadc_sample_pkg::*;
  import iadc_ctrl_pkg::*;
();

  logic                 adc_clk;
  logic                 rst;
  logic [7:0]           data_i_even;
  logic [7:0]           data_i_odd;
  logic [7:0]           data_q_even;
  logic [7:0]           data_q_odd;
  logic                 outofrange_i;
  logic                 outofrange_q;
  logic                 adc_sync;
  logic                 mode;
  logic                 ddrb_req;
  logic                 oor_clear;
  iadc_word_u           samples;
  logic                 sync_out;
  logic [3:0]           adc_outofrange;
  logic [1:0]           oor_sticky;
  logic [OOR_CNT_W-1:0] oor_count_i;
  logic [OOR_CNT_W-1:0] oor_count_q;
  logic                 adc_ddrb;

  int                   edge_idx;
  logic [63:0]          dual_hist[$];
  logic [63:0]          inter_hist[$];
  logic                 sync_hist[$];
  logic [3:0]           flag_hist[$];
  logic                 clr_prev;
  logic [1:0]           exp_sticky;
  logic [OOR_CNT_W-1:0] exp_cnt_i;
  logic [OOR_CNT_W-1:0] exp_cnt_q;
  int                   ddrb_rise;

  `include "iadc_tb_model.svh"

  iadc_infrastructure DUT (
    .adc_clk        (adc_clk),
    .rst            (rst),
    .data_i_even    (data_i_even),
    .data_i_odd     (data_i_odd),
    .data_q_even    (data_q_even),
    .data_q_odd     (data_q_odd),
    .outofrange_i   (outofrange_i),
    .outofrange_q   (outofrange_q),
    .adc_sync       (adc_sync),
    .mode           (mode),
    .ddrb_req       (ddrb_req),
    .oor_clear      (oor_clear),
    .samples        (samples),
    .sync_out       (sync_out),
    .adc_outofrange (adc_outofrange),
    .oor_sticky     (oor_sticky),
    .oor_count_i    (oor_count_i),
    .oor_count_q    (oor_count_q),
    .adc_ddrb       (adc_ddrb)
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  initial begin
    #1000000;
    $display("simulation ran past its time limit");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic logic random_flag();
    return ($urandom_range(3) == 0);  // sparse out-of-range.
  endfunction

  task automatic drive_pins(input logic [3:0][7:0] lanes, input logic [1:0] flags);
    data_i_even  = lanes[0];
    data_i_odd   = lanes[1];
    data_q_even  = lanes[2];
    data_q_odd   = lanes[3];
    outofrange_i = flags[0];
    outofrange_q = flags[1];
  endtask

  task automatic check_all_zero();
    check_equal("samples", samples, 64'h0);
    check_equal("sync_out", sync_out, 64'h0);
    check_equal("adc_outofrange", adc_outofrange, 64'h0);
    check_equal("oor_sticky", oor_sticky, 64'h0);
    check_equal("oor_count_i", oor_count_i, 64'h0);
    check_equal("oor_count_q", oor_count_q, 64'h0);
    check_equal("adc_ddrb", adc_ddrb, 64'h0);
  endtask

  // one adc_clk cycle with the next_* controls set up for the following edge.
  task automatic step_cycle(input logic next_req, input logic next_clr, input logic next_mode,
                            input logic next_sync, input bit oor_force);
    logic [3:0][7:0] rise_v;
    logic [3:0][7:0] fall_v;
    logic [1:0]      rise_f;
    logic [1:0]      fall_f;
    logic [3:0]      old_flags;
    logic            hit_i;
    logic            hit_q;
    @(posedge adc_clk);
    #0.5;
    edge_idx++;
    // outputs now show edge edge_idx-2 in the order that this edge's mode selects.
    check_equal("samples", samples,
                (mode == MODE_INTERLEAVED) ? inter_hist.pop_front() : dual_hist.pop_front());
    if (mode == MODE_INTERLEAVED) begin
      void'(dual_hist.pop_front());
    end else begin
      void'(inter_hist.pop_front());
    end
    check_equal("sync_out", sync_out, sync_hist.pop_front());
    old_flags = flag_hist.pop_front();
    check_equal("adc_outofrange", adc_outofrange, old_flags);
    hit_i      = old_flags[0] | old_flags[2];
    hit_q      = old_flags[1] | old_flags[3];
    exp_sticky = clr_prev ? 2'b00 : (exp_sticky | {hit_q, hit_i});
    exp_cnt_i  = next_count(exp_cnt_i, hit_i, clr_prev);
    exp_cnt_q  = next_count(exp_cnt_q, hit_q, clr_prev);
    check_equal("oor_sticky", oor_sticky, exp_sticky);
    check_equal("oor_count_i", oor_count_i, exp_cnt_i);
    check_equal("oor_count_q", oor_count_q, exp_cnt_q);
    check_equal("adc_ddrb", adc_ddrb, ddrb_expected(edge_idx, ddrb_rise));
    if (ddrb_req && ddrb_accepts(edge_idx, ddrb_rise)) begin
      ddrb_rise = edge_idx + 1;
    end
    clr_prev = oor_clear;
    // pins still hold the values sampled at this rising edge.
    rise_v = {data_q_odd, data_q_even, data_i_odd, data_i_even};
    rise_f = {outofrange_q, outofrange_i};
    fall_v = $urandom;
    fall_f = oor_force ? 2'b11 : {random_flag(), random_flag()};
    dual_hist.push_back(expect_dual(rise_v, fall_v));
    inter_hist.push_back(expect_inter(rise_v, fall_v));
    sync_hist.push_back(adc_sync);
    flag_hist.push_back({fall_f, rise_f});
    drive_pins(fall_v, fall_f);  // falling edge half.
    mode      = next_mode;
    adc_sync  = next_sync;
    ddrb_req  = next_req;
    oor_clear = next_clr;
    @(negedge adc_clk);
    #0.5;
    drive_pins($urandom, oor_force ? 2'b11 : {random_flag(), random_flag()});
  endtask

  task automatic wait_ddrb(input logic level, input int limit);
    int waited;
    waited = 0;
    while (adc_ddrb !== level) begin
      if (waited >= limit) begin
        $display("adc_ddrb did not reach %0b within %0d cycles", level, limit);
        $display("TESTBENCH FAILED");
        $fatal(1, "wait timed out");
      end
      step_cycle(1'b0, 1'b0, mode, adc_sync, 1'b0);
      waited++;
    end
  endtask

  initial begin
    int   high_cycles;
    logic r_mode;
    logic r_sync;
    void'($urandom(89754));
    rst = 1'b1;
    drive_pins('0, 2'b00);
    adc_sync    = 1'b0;
    mode        = MODE_DUAL;
    ddrb_req    = 1'b0;
    oor_clear   = 1'b0;
    edge_idx    = 0;
    clr_prev    = 1'b0;
    exp_sticky  = '0;
    exp_cnt_i   = '0;
    exp_cnt_q   = '0;
    ddrb_rise   = -1000;
    repeat (2) begin
      dual_hist.push_back(64'h0);
      inter_hist.push_back(64'h0);
      sync_hist.push_back(1'b0);
      flag_hist.push_back(4'h0);
    end
    repeat (2) begin
      @(posedge adc_clk);
      #0.5;
      edge_idx++;
      check_all_zero();  // held in reset.
    end
    rst = 1'b0;
    step_cycle(1'b0, 1'b0, MODE_DUAL, 1'b0, 1'b0);
    check_all_zero();  // first cycle out of reset.

    // random traffic with sparse mode flips and pulses.
    for (int n = 0; n < 3000; n++) begin
      r_mode = ($urandom_range(31) == 0) ? ~mode : mode;
      r_sync = ($urandom_range(3) == 0) ? ~adc_sync : adc_sync;
      step_cycle(($urandom_range(39) == 0), ($urandom_range(15) == 0), r_mode, r_sync, 1'b0);
    end

    // one reset pulse with a second request in the middle of it.
    wait_ddrb(1'b0, 40);
    step_cycle(1'b1, 1'b0, mode, adc_sync, 1'b0);
    wait_ddrb(1'b1, 4);
    high_cycles = 0;
    while (adc_ddrb === 1'b1) begin
      if (high_cycles > DDRB_CYCLES + 4) begin
        $display("adc_ddrb stayed high past its expected length");
        $display("TESTBENCH FAILED");
        $fatal(1, "pulse timed out");
      end
      high_cycles++;
      step_cycle((high_cycles == 4), 1'b0, mode, adc_sync, 1'b0);
    end
    check_equal("adc_ddrb pulse length", high_cycles, DDRB_CYCLES);

    // flags held high until both counters saturate.
    step_cycle(1'b0, 1'b1, MODE_DUAL, 1'b0, 1'b1);
    for (int n = 0; n < (1 << OOR_CNT_W) + 8; n++) begin
      step_cycle(1'b0, 1'b0, MODE_DUAL, 1'b0, 1'b1);
    end
    check_equal("oor_count_i", oor_count_i, {OOR_CNT_W{1'b1}});
    check_equal("oor_count_q", oor_count_q, {OOR_CNT_W{1'b1}});
    step_cycle(1'b0, 1'b1, MODE_DUAL, 1'b0, 1'b1);  // clear while flagged.
    repeat (4) step_cycle(1'b0, 1'b0, MODE_DUAL, 1'b0, 1'b0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+sim
source/iadc_sample_pkg.sv
source/iadc_ctrl_pkg.sv
source/iadc_ddr_capture.sv
source/iadc_sample_order.sv
source/iadc_oor_monitor.sv
source/iadc_ddrb_gen.sv
source/iadc_infrastructure.sv
sim/tb_iadc_infrastructure.sv

// File: Bender.yml
package:
  name: iadc_infrastructure

sources:
  - files:
      - source/iadc_sample_pkg.sv
      - source/iadc_ctrl_pkg.sv
      - source/iadc_ddr_capture.sv
      - source/iadc_sample_order.sv
      - source/iadc_oor_monitor.sv
      - source/iadc_ddrb_gen.sv
      - source/iadc_infrastructure.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_iadc_infrastructure.sv
